// File: sim.f
biu_pkg.sv
biu_req_router.sv
bank_biu.sv
biu_ar_arbiter.sv
biu_resp_merge.sv
biu_cluster_top.sv
biu_cluster_assert.sv
tb_biu_cluster.sv

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert --top-module tb_biu_cluster \
       -f sim.f -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "^TB PASSED$" \
  && echo "run_sim: simulation passed" \
  || { echo "run_sim: simulation failed"; exit 1; }

// File: tb_biu_cluster.sv
`timescale 1ns/1ps
`default_nettype none

module tb_biu_cluster
  import biu_pkg::*;
();

  localparam int NUM_BANKS      = 4;
  localparam int NUM_ENTRIES    = 8;
  localparam int TIMEOUT_CYCLES = 40 * NUM_ENTRIES + 100;

  typedef struct packed {
    logic [LINE_ADDR_W-1:0] line_addr;
    logic [SET_WAY_W-1:0]   set_way;
    logic [1:0]             rresp;
    logic [31:0]            stall;
  } stim_t;

  // one accepted AR waiting for its R beat
  typedef struct packed {
    logic [AXI_ID_W-1:0] id;
    logic [31:0]         addr;
    logic [1:0]          resp;
    logic [31:0]         due;
  } pend_t;

  logic       clk_i;
  logic       rst_i;
  logic       htu_valid_i;
  logic       htu_ready_o;
  biu_req_t   htu_req_i;
  logic       isu_valid_o;
  logic       isu_ready_i;
  biu_rsp_t   isu_rsp_o;
  logic       axi_ar_valid_o;
  logic       axi_ar_ready_i;
  biu_ar_t    axi_ar_o;
  logic [2:0] axi_ar_size_o;
  logic [3:0] axi_ar_len_o;
  logic [1:0] axi_ar_burst_o;
  logic       axi_r_valid_i;
  logic       axi_r_ready_o;
  biu_r_t     axi_r_i;

  int    cycle_cnt = 0;
  int    seed = 18439;
  int    accepted = 0;
  int    delivered = 0;
  int    max_wait = 0;
  logic  seen [NUM_ENTRIES];
  pend_t pend_q [$];

  // --------------------
  // stimulus table
  // --------------------
  // first four go to banks 0..3 back to back, then three pile onto bank 1
  // fields: line address, set_way, rresp, isu stall cycles
  stim_t stim [NUM_ENTRIES] = '{
    '{27'h0001000, 6'h01, 2'b00, 32'd8},
    '{27'h0002341, 6'h12, 2'b00, 32'd9},
    '{27'h00aa5a2, 6'h23, 2'b10, 32'd8},
    '{27'h1234563, 6'h34, 2'b00, 32'd10},
    '{27'h0400005, 6'h05, 2'b00, 32'd12},
    '{27'h0400009, 6'h16, 2'b11, 32'd0},
    '{27'h07ffffd, 6'h27, 2'b00, 32'd2},
    '{27'h5555554, 6'h38, 2'b00, 32'd0}
  };
  string stim_name [NUM_ENTRIES] = '{
    "bank0_ok", "bank1_ok", "bank2_slverr", "bank3_ok",
    "bank1_stall", "bank1_decerr", "bank1_again", "bank0_tail"
  };

  biu_cluster_top #(.NUM_BANKS(NUM_BANKS)) u_biu_cluster_top (
    .clk_i, .rst_i,
    .htu_valid_i, .htu_ready_o, .htu_req_i,
    .isu_valid_o, .isu_ready_i, .isu_rsp_o,
    .axi_ar_valid_o, .axi_ar_ready_i, .axi_ar_o,
    .axi_ar_size_o, .axi_ar_len_o, .axi_ar_burst_o,
    .axi_r_valid_i, .axi_r_ready_o, .axi_r_i
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // --------------------
  // helpers
  // --------------------
  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_ar(input string name, input biu_ar_t exp, input biu_ar_t act);
    if (act !== exp) begin
      stop_with_error($sformatf("Mismatch %s AR: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_ar_ctrl(input string name, input logic [8:0] exp, input logic [8:0] act);
    if (act !== exp) begin
      stop_with_error($sformatf("Mismatch %s AR size/len/burst: expected %h, actual %h",
                                name, exp, act));
    end
  endtask

  task automatic check_rsp(input string name, input biu_rsp_t exp, input biu_rsp_t act);
    if (act !== exp) begin
      stop_with_error($sformatf("Mismatch %s isu response: expected %h, actual %h",
                                name, exp, act));
    end
  endtask

  // lane k holds the byte address xor k
  function automatic logic [LINE_W-1:0] line_data(input logic [31:0] addr);
    logic [LINE_W-1:0] d;
    for (int k = 0; k < LINE_W / 32; k++) begin
      d[k*32 +: 32] = addr ^ 32'(k);
    end
    return d;
  endfunction

  function automatic int entry_by_sw(input logic [SET_WAY_W-1:0] sw);
    int idx;
    idx = -1;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (stim[i].set_way == sw) begin
        idx = i;
      end
    end
    return idx;
  endfunction

  // --------------------
  // AXI3 read memory
  // --------------------
  initial begin : axi_mem
    pend_t   p;
    biu_ar_t exp_ar;
    biu_r_t  beat;
    int      idx;
    int      pick;
    int      delay;
    logic    r_done;
    logic    ar_next;
    axi_ar_ready_i <= 1'b0;
    axi_r_valid_i  <= 1'b0;
    axi_r_i        <= '0;
    wait (rst_i === 1'b0);
    @(posedge clk_i);
    forever begin
      @(negedge clk_i);
      r_done = axi_r_valid_i && axi_r_ready_o;
      // ready answers a waiting AR one cycle late
      ar_next = axi_ar_valid_o && !axi_ar_ready_i;
      if (axi_ar_valid_o && axi_ar_ready_i) begin
        idx = entry_by_sw(axi_ar_o.id[SET_WAY_W-1:0]);
        if (idx < 0) begin
          stop_with_error("AR id carries a set_way that is in no table entry");
        end
        exp_ar.id   = {stim[idx].line_addr[BANK_ID_W-1:0], stim[idx].set_way};
        exp_ar.addr = {stim[idx].line_addr, 5'b00000};
        check_ar(stim_name[idx], exp_ar, axi_ar_o);
        check_ar_ctrl(stim_name[idx], {3'b101, 4'b0000, 2'b01},
                      {axi_ar_size_o, axi_ar_len_o, axi_ar_burst_o});
        // address already checked, so this entry also gives the rresp
        delay  = $unsigned($random(seed)) % 4;
        p.id   = axi_ar_o.id;
        p.addr = axi_ar_o.addr;
        p.resp = stim[idx].rresp;
        p.due  = cycle_cnt + delay;
        pend_q.push_back(p);
      end
      @(posedge clk_i);
      axi_ar_ready_i <= ar_next;
      if (r_done || !axi_r_valid_i) begin
        pick = -1;
        foreach (pend_q[j]) begin
          if (pick < 0 && pend_q[j].due <= cycle_cnt) begin
            pick = j;
          end
        end
        if (pick >= 0) begin
          beat.id   = pend_q[pick].id;
          beat.data = line_data(pend_q[pick].addr);
          beat.resp = pend_q[pick].resp;
          axi_r_valid_i <= 1'b1;
          axi_r_i       <= beat;
          pend_q.delete(pick);
        end else begin
          axi_r_valid_i <= 1'b0;
        end
      end
    end
  end

  // --------------------
  // isu sink
  // --------------------
  initial begin : isu_sink
    int       idx;
    int       waited;
    logic     next_ready;
    biu_rsp_t exp_rsp;
    isu_ready_i <= 1'b0;
    waited = 0;
    foreach (seen[i]) begin
      seen[i] = 1'b0;
    end
    wait (rst_i === 1'b0);
    forever begin
      @(negedge clk_i);
      next_ready = isu_ready_i;
      if (isu_valid_o) begin
        idx = entry_by_sw(isu_rsp_o.set_way);
        if (idx < 0) begin
          stop_with_error("isu response carries a set_way that is in no table entry");
        end
      end
      if (isu_valid_o && isu_ready_i) begin
        if (seen[idx]) begin
          stop_with_error("a second isu response arrived for one table entry");
        end
        if (delivered == 0 && accepted < NUM_BANKS) begin
          stop_with_error("a response was taken before the first misses were all accepted");
        end
        exp_rsp.data    = line_data({stim[idx].line_addr, 5'b00000});
        exp_rsp.set_way = stim[idx].set_way;
        exp_rsp.err     = (stim[idx].rresp != 2'b00);
        check_rsp(stim_name[idx], exp_rsp, isu_rsp_o);
        seen[idx] = 1'b1;
        delivered++;
        waited = 0;
        next_ready = 1'b0;
      end else if (isu_valid_o) begin
        // hold ready low for the entry's stall count
        if (waited >= stim[idx].stall) begin
          next_ready = 1'b1;
        end else begin
          waited++;
        end
      end
      @(posedge clk_i);
      isu_ready_i <= next_ready;
    end
  end

  initial begin : watchdog
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    stop_with_error($sformatf("timeout after %0d cycles with %0d of %0d responses",
                              cycle_cnt, delivered, NUM_ENTRIES));
  end

  // --------------------
  // reset and htu driver
  // --------------------
  initial begin : htu_driver
    int wait_cycles;
    rst_i       <= 1'b1;
    htu_valid_i <= 1'b0;
    htu_req_i   <= '0;
    repeat (16) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      htu_valid_i <= 1'b1;
      htu_req_i   <= {stim[i].line_addr, stim[i].set_way};
      wait_cycles = 0;
      @(negedge clk_i);
      while (!htu_ready_o) begin
        wait_cycles++;
        @(negedge clk_i);
      end
      if (wait_cycles > max_wait) begin
        max_wait = wait_cycles;
      end
      // transfer happens on this edge
      @(posedge clk_i);
      accepted++;
    end
    htu_valid_i <= 1'b0;
    wait (delivered == NUM_ENTRIES);
    repeat (4) @(posedge clk_i);
    if (max_wait < 4) begin
      stop_with_error("htu_ready_o never stayed low for a request to a busy bank");
    end
    if (pend_q.size() != 0 || isu_valid_o) begin
      stop_with_error("traffic is still pending after the last response");
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: biu_cluster_assert.sv
`timescale 1ns/1ps
`default_nettype none

module biu_cluster_assert
  import biu_pkg::*;
(
  input logic     clk_i,
  input logic     rst_i,
  input logic     axi_ar_valid_o,
  input logic     axi_ar_ready_i,
  input biu_ar_t  axi_ar_o,
  input logic     isu_valid_o,
  input logic     isu_ready_i,
  input biu_rsp_t isu_rsp_o
);

  // ar must not move while the bus stalls
  a_ar_stable: assert property (
    @(posedge clk_i) disable iff (rst_i)
    axi_ar_valid_o && !axi_ar_ready_i |=> axi_ar_valid_o && $stable(axi_ar_o)
  ) else $error("AR valid dropped or payload changed before ready");

  // isu response held until taken
  a_isu_hold: assert property (
    @(posedge clk_i) disable iff (rst_i)
    isu_valid_o && !isu_ready_i |=> isu_valid_o && $stable(isu_rsp_o)
  ) else $error("isu valid dropped or payload changed before ready");

  a_reset_quiet: assert property (
    @(posedge clk_i) rst_i |-> !axi_ar_valid_o && !isu_valid_o
  ) else $error("valid output high during reset");

endmodule

bind biu_cluster_top biu_cluster_assert u_assert (
  .clk_i(clk_i),
  .rst_i(rst_i),
  .axi_ar_valid_o(axi_ar_valid_o),
  .axi_ar_ready_i(axi_ar_ready_i),
  .axi_ar_o(axi_ar_o),
  .isu_valid_o(isu_valid_o),
  .isu_ready_i(isu_ready_i),
  .isu_rsp_o(isu_rsp_o)
);

`default_nettype wire

// File: biu_cluster_top.sv
`timescale 1ns/1ps
`default_nettype none

module biu_cluster_top
  import biu_pkg::*;
#(
  parameter int NUM_BANKS = 4
) (
  input  logic     clk_i,
  input  logic     rst_i,
  // htu miss requests
  input  logic     htu_valid_i,
  output logic     htu_ready_o,
  input  biu_req_t htu_req_i,
  // completed lines to isu
  output logic     isu_valid_o,
  input  logic     isu_ready_i,
  output biu_rsp_t isu_rsp_o,
  // axi3 read address
  output logic     axi_ar_valid_o,
  input  logic     axi_ar_ready_i,
  output biu_ar_t  axi_ar_o,
  output logic [2:0] axi_ar_size_o,
  output logic [3:0] axi_ar_len_o,
  output logic [1:0] axi_ar_burst_o,
  // axi3 read data
  input  logic     axi_r_valid_i,
  output logic     axi_r_ready_o,
  input  biu_r_t   axi_r_i
);

  logic     [NUM_BANKS-1:0] req_valid;
  logic     [NUM_BANKS-1:0] req_ready;
  biu_req_t                 req;
  logic     [NUM_BANKS-1:0] ar_valid;
  logic     [NUM_BANKS-1:0] ar_ready;
  biu_ar_t  [NUM_BANKS-1:0] ar;
  logic     [NUM_BANKS-1:0] r_valid;
  logic     [NUM_BANKS-1:0] r_ready;
  biu_r_t                   r;
  logic     [NUM_BANKS-1:0] rsp_valid;
  logic     [NUM_BANKS-1:0] rsp_ready;
  biu_rsp_t [NUM_BANKS-1:0] rsp;

  // 32-byte single-beat incrementing reads
  assign axi_ar_size_o  = 3'b101;
  assign axi_ar_len_o   = 4'b0000;
  assign axi_ar_burst_o = 2'b01;

  biu_req_router #(.NUM_BANKS(NUM_BANKS)) u_router (
    .clk_i, .rst_i, .htu_valid_i, .htu_ready_o, .htu_req_i,
    .bank_valid_o(req_valid), .bank_ready_i(req_ready), .bank_req_o(req)
  );

  // --------------------
  // banks
  // --------------------
  for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
    bank_biu #(.BANK_IDX(g)) u_bank (
      .clk_i, .rst_i,
      .req_valid_i(req_valid[g]), .req_ready_o(req_ready[g]), .req_i(req),
      .ar_valid_o(ar_valid[g]), .ar_ready_i(ar_ready[g]), .ar_o(ar[g]),
      .r_valid_i(r_valid[g]), .r_ready_o(r_ready[g]), .r_i(r),
      .rsp_valid_o(rsp_valid[g]), .rsp_ready_i(rsp_ready[g]), .rsp_o(rsp[g])
    );
  end

  biu_ar_arbiter #(.NUM_BANKS(NUM_BANKS)) u_ar_arb (
    .clk_i, .rst_i,
    .bank_ar_valid_i(ar_valid), .bank_ar_ready_o(ar_ready), .bank_ar_i(ar),
    .axi_ar_valid_o, .axi_ar_ready_i, .axi_ar_o,
    .axi_r_valid_i, .axi_r_ready_o, .axi_r_i,
    .bank_r_valid_o(r_valid), .bank_r_ready_i(r_ready), .bank_r_o(r)
  );

  biu_resp_merge #(.NUM_BANKS(NUM_BANKS)) u_merge (
    .clk_i, .rst_i,
    .bank_rsp_valid_i(rsp_valid), .bank_rsp_ready_o(rsp_ready), .bank_rsp_i(rsp),
    .isu_valid_o, .isu_ready_i, .isu_rsp_o
  );

endmodule

`default_nettype wire

// File: biu_resp_merge.sv
`timescale 1ns/1ps
`default_nettype none

module biu_resp_merge
  import biu_pkg::*;
#(
  parameter int NUM_BANKS = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  // bank responses
  input  logic     [NUM_BANKS-1:0] bank_rsp_valid_i,
  output logic     [NUM_BANKS-1:0] bank_rsp_ready_o,
  input  biu_rsp_t [NUM_BANKS-1:0] bank_rsp_i,
  // isu port
  output logic                    isu_valid_o,
  input  logic                    isu_ready_i,
  output biu_rsp_t                isu_rsp_o
);

  localparam int BSEL_W = $clog2(NUM_BANKS);

  logic [BSEL_W-1:0] rr_ptr_q;
  logic [BSEL_W-1:0] hold_idx_q;
  logic              holding_q;
  logic [BSEL_W-1:0] pick;
  logic              found;
  logic [BSEL_W-1:0] sel;

  // --------------------
  // selection
  // --------------------
  always_comb begin
    found = 1'b0;
    pick  = rr_ptr_q;
    for (int i = 0; i < NUM_BANKS; i++) begin
      if (!found && bank_rsp_valid_i[rr_ptr_q + BSEL_W'(i)]) begin
        found = 1'b1;
        pick  = rr_ptr_q + BSEL_W'(i);
      end
    end
  end

  // a stalled isu keeps the same bank so the payload stays put
  assign sel              = holding_q ? hold_idx_q : pick;
  assign isu_valid_o      = bank_rsp_valid_i[sel];
  assign isu_rsp_o        = bank_rsp_i[sel];
  assign bank_rsp_ready_o = {NUM_BANKS{isu_ready_i}} & (NUM_BANKS'(1) << sel);

  // priority moves past the winner after each transfer
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rr_ptr_q   <= '0;
      hold_idx_q <= '0;
      holding_q  <= 1'b0;
    end else if (isu_valid_o && isu_ready_i) begin
      rr_ptr_q  <= sel + BSEL_W'(1);
      holding_q <= 1'b0;
    end else if (isu_valid_o) begin
      hold_idx_q <= sel;
      holding_q  <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: biu_ar_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module biu_ar_arbiter
  import biu_pkg::*;
#(
  parameter int NUM_BANKS = 4
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  // bank ar requests
  input  logic    [NUM_BANKS-1:0]        bank_ar_valid_i,
  output logic    [NUM_BANKS-1:0]        bank_ar_ready_o,
  input  biu_ar_t [NUM_BANKS-1:0]        bank_ar_i,
  // axi3 ar channel
  output logic                           axi_ar_valid_o,
  input  logic                           axi_ar_ready_i,
  output biu_ar_t                        axi_ar_o,
  // axi3 r channel
  input  logic                           axi_r_valid_i,
  output logic                           axi_r_ready_o,
  input  biu_r_t                         axi_r_i,
  // r beats to banks
  output logic    [NUM_BANKS-1:0]        bank_r_valid_o,
  input  logic    [NUM_BANKS-1:0]        bank_r_ready_i,
  output biu_r_t                         bank_r_o
);

  localparam int BSEL_W = $clog2(NUM_BANKS);

  logic [BSEL_W-1:0]    rr_ptr_q;
  logic [BSEL_W-1:0]    grant_q;
  logic                 locked_q;
  logic [BSEL_W-1:0]    pick;
  logic                 found;
  logic [BSEL_W-1:0]    grant;
  logic [BANK_ID_W-1:0] r_bank;
  logic [BSEL_W-1:0]    r_dest;

  // --------------------
  // ar grant
  // --------------------
  // first valid bank at or after the priority pointer
  always_comb begin
    found = 1'b0;
    pick  = rr_ptr_q;
    for (int i = 0; i < NUM_BANKS; i++) begin
      if (!found && bank_ar_valid_i[rr_ptr_q + BSEL_W'(i)]) begin
        found = 1'b1;
        pick  = rr_ptr_q + BSEL_W'(i);
      end
    end
  end

  assign grant           = locked_q ? grant_q : pick;
  assign axi_ar_valid_o  = bank_ar_valid_i[grant];
  assign axi_ar_o        = bank_ar_i[grant];
  assign bank_ar_ready_o = {NUM_BANKS{axi_ar_ready_i}} & (NUM_BANKS'(1) << grant);

  // hold the grant until the bus takes it, then rotate
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rr_ptr_q <= '0;
      grant_q  <= '0;
      locked_q <= 1'b0;
    end else if (axi_ar_valid_o && axi_ar_ready_i) begin
      rr_ptr_q <= grant + BSEL_W'(1);
      locked_q <= 1'b0;
    end else if (axi_ar_valid_o) begin
      grant_q  <= grant;
      locked_q <= 1'b1;
    end
  end

  // --------------------
  // r routing
  // --------------------
  assign r_bank         = axi_r_i.id[AXI_ID_W-1 -: BANK_ID_W];
  assign r_dest         = r_bank[BSEL_W-1:0];
  assign bank_r_valid_o = axi_r_valid_i ? (NUM_BANKS'(1) << r_dest) : '0;
  assign axi_r_ready_o  = bank_r_ready_i[r_dest];
  assign bank_r_o       = axi_r_i;

endmodule

`default_nettype wire

// File: bank_biu.sv
`timescale 1ns/1ps
`default_nettype none

module bank_biu
  import biu_pkg::*;
#(
  parameter int BANK_IDX = 0
) (
  input  logic     clk_i,
  input  logic     rst_i,
  // from router
  input  logic     req_valid_i,
  output logic     req_ready_o,
  input  biu_req_t req_i,
  // to ar arbiter
  output logic     ar_valid_o,
  input  logic     ar_ready_i,
  output biu_ar_t  ar_o,
  // routed r beat
  input  logic     r_valid_i,
  output logic     r_ready_o,
  input  biu_r_t   r_i,
  // to merger
  output logic     rsp_valid_o,
  input  logic     rsp_ready_i,
  output biu_rsp_t rsp_o
);

  bank_state_e            state_q;
  logic [LINE_ADDR_W-1:0] line_addr_q;
  logic [SET_WAY_W-1:0]   set_way_q;
  logic [LINE_W-1:0]      data_q;
  logic                   err_q;

  // --------------------
  // handshake outputs
  // --------------------
  assign req_ready_o = (state_q == IDLE);
  assign ar_valid_o  = (state_q == ADDR);
  assign r_ready_o   = (state_q == WAIT_R);
  assign rsp_valid_o = (state_q == RESP);

  // aligned 32-byte read, bank index in the upper id bits
  assign ar_o.id   = {BANK_ID_W'(BANK_IDX), set_way_q};
  assign ar_o.addr = {line_addr_q, 5'b00000};

  assign rsp_o.data    = data_q;
  assign rsp_o.set_way = set_way_q;
  assign rsp_o.err     = err_q;

  // --------------------
  // miss FSM
  // --------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:    if (req_valid_i) state_q <= ADDR;
        ADDR:    if (ar_ready_i) state_q <= WAIT_R;
        WAIT_R:  if (r_valid_i) state_q <= RESP;
        RESP:    if (rsp_ready_i) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      line_addr_q <= req_i.line_addr;
      set_way_q   <= req_i.set_way;
    end
    // anything but OKAY is flagged, no retry
    if (r_valid_i && r_ready_o) begin
      data_q <= r_i.data;
      err_q  <= (r_i.resp != 2'b00);
    end
  end

endmodule

`default_nettype wire

// File: biu_req_router.sv
`timescale 1ns/1ps
`default_nettype none

module biu_req_router
  import biu_pkg::*;
#(
  parameter int NUM_BANKS = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  // htu side
  input  logic                 htu_valid_i,
  output logic                 htu_ready_o,
  input  biu_req_t             htu_req_i,
  // bank side
  output logic [NUM_BANKS-1:0] bank_valid_o,
  input  logic [NUM_BANKS-1:0] bank_ready_i,
  output biu_req_t             bank_req_o
);

  localparam int BSEL_W = $clog2(NUM_BANKS);

  logic              hold_valid_q;
  biu_req_t          hold_req_q;
  logic [BSEL_W-1:0] bank_sel;

  // low line bits pick the bank
  assign bank_sel    = hold_req_q.line_addr[BSEL_W-1:0];
  assign htu_ready_o = ~hold_valid_q;
  assign bank_req_o  = hold_req_q;

  // only the selected bank sees valid
  assign bank_valid_o = hold_valid_q ? (NUM_BANKS'(1) << bank_sel) : '0;

  // --------------------
  // holding register
  // --------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      hold_valid_q <= 1'b0;
    end else if (htu_valid_i && htu_ready_o) begin
      hold_valid_q <= 1'b1;
    end else if (hold_valid_q && bank_ready_i[bank_sel]) begin
      hold_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (htu_valid_i && htu_ready_o) begin
      hold_req_q <= htu_req_i;
    end
  end

endmodule

`default_nettype wire

// File: biu_pkg.sv
`default_nettype none

package biu_pkg;

  // --------------------
  // field widths
  // --------------------
  localparam int LINE_ADDR_W = 27;
  localparam int SET_WAY_W   = 6;
  localparam int BANK_ID_W   = 2;
  localparam int AXI_ID_W    = BANK_ID_W + SET_WAY_W;
  localparam int LINE_W      = 256;

  // --------------------
  // payload types
  // --------------------
  // miss request from the htu, address bits 31:5
  typedef struct packed {
    logic [LINE_ADDR_W-1:0] line_addr;
    logic [SET_WAY_W-1:0]   set_way;
  } biu_req_t;

  // id is {bank, set_way}
  typedef struct packed {
    logic [AXI_ID_W-1:0] id;
    logic [31:0]         addr;
  } biu_ar_t;

  // single-beat read data, rlast not carried
  typedef struct packed {
    logic [AXI_ID_W-1:0] id;
    logic [LINE_W-1:0]   data;
    logic [1:0]          resp;
  } biu_r_t;

  typedef struct packed {
    logic [LINE_W-1:0]    data;
    logic [SET_WAY_W-1:0] set_way;
    logic                 err;
  } biu_rsp_t;

  typedef enum logic [1:0] {
    IDLE,
    ADDR,
    WAIT_R,
    RESP
  } bank_state_e;

endpackage

`default_nettype wire
